// File: src.f
common/datapathPkg.sv
design/registerFile.sv
design/forwardingUnit.sv
design/decodeStage.sv
execute/aluCore.sv
execute/executeStage.sv
memory/memoryStage.sv
design/pipelineDatapath.sv
verification/clockGen.sv
verification/pipelineDatapathTb.sv

// File: Makefile
TOP = pipelineDatapathTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	grep -F -q "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/pipelineDatapathTb.sv
`default_nettype none

module pipelineDatapathTb;

   import datapathPkg::*;

   // One issue slot with the expected responses
   typedef struct packed {
      logic         valid;
      instrFields_t fields;
      ctrl_t        ctrl;
      logic         expWb;
      regIdx_t      expReg;
      word_t        expData;
      aluFlags_t    expFlags;
      logic         expZero;
   } stepEntry_t;

   logic         clk;
   logic         rstN;
   logic         instrValid;
   instrFields_t fields;
   ctrl_t        ctrl;
   logic         zeroFlag;
   aluFlags_t    flags;
   logic         wbValid;
   regIdx_t      wbReg;
   word_t        wbData;

   stepEntry_t steps [$];
   stepEntry_t pending [$];
   stepEntry_t lastStep;
   logic       haveLast = 1'b0;
   logic       tableBuilt = 1'b0;

   // Sequential reference state
   word_t      modelRegs [REG_COUNT];
   logic [7:0] modelMem [DMEM_BYTES];

   clockGen clockGen_i (.clk, .rstN);

   pipelineDatapath pipelineDatapath_i (
      .clk, .rstN, .instrValid, .fields, .ctrl,
      .zeroFlag, .flags, .wbValid, .wbReg, .wbData
   );

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "stopped on the first error");
   endtask

   task automatic compareWord(input word_t got, input word_t exp, input string what);
      if (got !== exp)
         failRun($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, exp));
   endtask

   task automatic compareFlags(input aluFlags_t got, input aluFlags_t exp, input string what);
      if (got !== exp)
         failRun($sformatf("Fail at %0t: %s NVC is %b, expected %b", $time, what, got, exp));
   endtask

   task automatic compareReg(input regIdx_t got, input regIdx_t exp, input string what);
      if (got !== exp)
         failRun($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp));
   endtask

   task automatic compareBit(input logic got, input logic exp, input string what);
      if (got !== exp)
         failRun($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, exp));
   endtask

   function automatic word_t readModel(input regIdx_t r);
      return (r == regIdx_t'(ZERO_REG)) ? '0 : modelRegs[r];
   endfunction

   function automatic instrFields_t fieldsOf(input int rd, input int rn, input int rm,
                                             input int daddr, input int imm12,
                                             input int shamt, input int imm16);
      instrFields_t f;
      f.rd     = regIdx_t'(rd);
      f.rn     = regIdx_t'(rn);
      f.rm     = regIdx_t'(rm);
      f.daddr9 = 9'(daddr);
      f.imm12  = 12'(imm12);
      f.shamt  = 2'(shamt);
      f.imm16  = 16'(imm16);
      return f;
   endfunction

   // Runs one instruction through the reference model and queues it
   task automatic issue(input logic valid, input instrFields_t f, input ctrl_t c);
      stepEntry_t  s;
      word_t       a;
      word_t       bVal;
      word_t       cand;
      word_t       field;
      word_t       opB;
      word_t       res;
      word_t       wb;
      logic [64:0] sWide;
      dmemAddr_t   addr;
      int          sh;
      a    = readModel(f.rn);
      bVal = readModel(c.reg2Loc ? f.rd : f.rm);
      if (c.chooseImm) cand = 64'(f.imm12);
      else if (c.aluSrc) cand = {{55{f.daddr9[8]}}, f.daddr9};
      else cand = bVal;
      sh    = 16 * f.shamt;
      field = 64'(f.imm16) << sh;
      if (c.chooseMovz) opB = field;
      else if (c.chooseMovk) opB = (bVal & ~(64'hFFFF << sh)) | field;
      else opB = cand;
      s         = '0;
      s.valid   = valid;
      s.fields  = f;
      s.ctrl    = c;
      s.expZero = (cand == '0);
      if (valid) begin
         case (c.aluOp)
            ALU_ADD: begin
               res = a + opB;
               // An unsigned sum below an addend has wrapped
               s.expFlags.carryOut = (res < a);
               // Exact signed sum in 65 bits
               sWide = {a[63], a} + {opB[63], opB};
               // Top two bits differ when it leaves the 64-bit range
               s.expFlags.overflow = (sWide[64] != sWide[63]);
            end
            ALU_SUB: begin
               res = a - opB;
               // Carry means no borrow
               s.expFlags.carryOut = (a >= opB);
               sWide = {a[63], a} - {opB[63], opB};
               s.expFlags.overflow = (sWide[64] != sWide[63]);
            end
            ALU_AND: res = a & opB;
            ALU_OR:  res = a | opB;
            ALU_XOR: res = a ^ opB;
            default: res = opB;
         endcase
         s.expFlags.negative = res[63];
         addr = res[7:0];
         wb   = res;
         if (c.memRead) begin
            wb = '0;
            for (int i = 0; i < (c.xferByte ? 1 : 8); i++)
               wb[8*i +: 8] = modelMem[dmemAddr_t'(addr + i)];
         end
         if (c.memWrite) begin
            for (int i = 0; i < (c.xferByte ? 1 : 8); i++)
               modelMem[dmemAddr_t'(addr + i)] = bVal[8*i +: 8];
         end
         if (c.regWrite) begin
            s.expWb   = 1'b1;
            s.expReg  = f.rd;
            s.expData = wb;
            if (f.rd != regIdx_t'(ZERO_REG)) modelRegs[f.rd] = wb;
         end
      end
      steps.push_back(s);
   endtask

   task automatic regOp(input aluOp_t op, input int rd, input int rn, input int rm);
      ctrl_t c;
      c          = '0;
      c.regWrite = 1'b1;
      c.aluOp    = op;
      issue(1'b1, fieldsOf(rd, rn, rm, 0, 0, 0, 0), c);
   endtask

   task automatic addImm(input int rd, input int rn, input int imm12);
      ctrl_t c;
      c           = '0;
      c.regWrite  = 1'b1;
      c.chooseImm = 1'b1;
      c.aluOp     = ALU_ADD;
      issue(1'b1, fieldsOf(rd, rn, 31, 0, imm12, 0, 0), c);
   endtask

   // MOVZ, or MOVK when keep is set (old Rd comes in on port B)
   task automatic moveWide(input int rd, input int imm16, input int shamt, input logic keep);
      ctrl_t c;
      c            = '0;
      c.regWrite   = 1'b1;
      c.aluOp      = ALU_PASSB;
      c.reg2Loc    = keep;
      c.chooseMovk = keep;
      c.chooseMovz = !keep;
      issue(1'b1, fieldsOf(rd, 31, 31, 0, 0, shamt, imm16), c);
   endtask

   task automatic memAccess(input int rt, input int rn, input int off,
                            input logic isStore, input logic isByte);
      ctrl_t c;
      c          = '0;
      c.aluSrc   = 1'b1;
      c.aluOp    = ALU_ADD;
      c.xferByte = isByte;
      c.reg2Loc  = isStore;
      c.memWrite = isStore;
      c.memRead  = !isStore;
      c.memToReg = !isStore;
      c.regWrite = !isStore;
      issue(1'b1, fieldsOf(rt, rn, 31, off, 0, 0, 0), c);
   endtask

   task automatic insertBubble();
      issue(1'b0, fieldsOf(31, 31, 31, 0, 0, 0, 0), '0);
   endtask

   // MOVZ at the first field, then MOVK into the other three
   task automatic buildConstant(input int rd, input word_t value, input int firstShamt);
      moveWide(rd, int'(value[16*firstShamt +: 16]), firstShamt, 1'b0);
      for (int s = 0; s < 4; s++) begin
         if (s != firstShamt) moveWide(rd, int'(value[16*s +: 16]), s, 1'b1);
      end
   endtask

   task automatic buildProgram();
      for (int i = 0; i < REG_COUNT; i++) modelRegs[i] = '0;
      buildConstant(1, {$urandom, $urandom}, 0);
      buildConstant(2, {$urandom, $urandom}, 2);
      buildConstant(7, {$urandom, $urandom}, 1);
      buildConstant(8, {$urandom, $urandom}, 3);
      insertBubble();
      // Dependent chain bypassing from execute and memory
      regOp(ALU_ADD, 9, 1, 2);
      regOp(ALU_SUB, 10, 1, 2);
      regOp(ALU_AND, 11, 9, 10);
      regOp(ALU_OR, 12, 11, 7);
      regOp(ALU_XOR, 13, 12, 11);
      insertBubble();
      regOp(ALU_ADD, 14, 13, 8);
      regOp(ALU_SUB, 15, 14, 13);
      // Signed overflow and carry corners
      moveWide(3, 16'h8000, 3, 1'b0);
      addImm(4, 31, 1);
      regOp(ALU_SUB, 5, 3, 4);
      regOp(ALU_SUB, 6, 4, 3);
      regOp(ALU_SUB, 16, 4, 4);
      regOp(ALU_ADD, 17, 3, 3);
      regOp(ALU_AND, 29, 1, 16);
      addImm(30, 1, 0);
      // Base 0x80 with positive and negative offsets
      addImm(20, 31, 12'h080);
      memAccess(1, 20, -8, 1'b1, 1'b0);
      memAccess(2, 20, 16, 1'b1, 1'b0);
      memAccess(8, 20, -24, 1'b1, 1'b0);
      memAccess(21, 20, -8, 1'b0, 1'b0);
      memAccess(22, 20, 16, 1'b0, 1'b0);
      insertBubble();
      regOp(ALU_ADD, 23, 21, 22);
      memAccess(26, 20, -24, 1'b0, 1'b0);
      memAccess(7, 20, 3, 1'b1, 1'b1);
      memAccess(24, 20, 3, 1'b0, 1'b1);
      insertBubble();
      regOp(ALU_OR, 25, 24, 31);
      regOp(ALU_XOR, 18, 26, 8);
      // Writes to the zero register vanish
      addImm(31, 31, 12'h05A);
      regOp(ALU_ADD, 27, 31, 1);
      regOp(ALU_OR, 28, 1, 31);
      // Drain the pipe
      repeat (3) insertBubble();
   endtask

   task automatic checkWriteback(input stepEntry_t e);
      compareBit(wbValid, e.expWb, "wbValid");
      if (e.expWb) begin
         compareReg(wbReg, e.expReg, "wbReg");
         compareWord(wbData, e.expData, "wbData");
      end
   endtask

   // Called on a falling edge
   task automatic runStep(input stepEntry_t s);
      if (haveLast && lastStep.valid) compareFlags(flags, lastStep.expFlags, "flags");
      if (pending.size() == 3) checkWriteback(pending.pop_front());
      instrValid = s.valid;
      fields     = s.fields;
      ctrl       = s.ctrl;
      pending.push_back(s);
      lastStep = s;
      haveLast = 1'b1;
      // zeroFlag settles mid low phase
      #2;
      compareBit(zeroFlag, s.expZero, "zeroFlag");
   endtask

   initial begin
      void'($urandom(31));
      instrValid = 1'b0;
      fields     = fieldsOf(31, 31, 31, 0, 0, 0, 0);
      ctrl       = '0;
      buildProgram();
      tableBuilt = 1'b1;
      @(posedge rstN);
      @(negedge clk);
      for (int i = 0; i < steps.size(); i++) begin
         runStep(steps[i]);
         @(negedge clk);
      end
      $display("*** PASSED ***");
      $finish;
   end

   // Budget is one cycle per table entry plus reset and slack
   initial begin
      wait (tableBuilt);
      repeat (steps.size() + 10) @(posedge clk);
      failRun("Timeout: the table did not finish within its cycle budget");
   end

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`default_nettype none

module clockGen (
   output logic clk,
   output logic rstN
);

   // 8-unit period
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Reset held over 3 rising edges and released on a falling edge
   initial begin
      rstN = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
   end

endmodule

`default_nettype wire

// File: design/pipelineDatapath.sv
`default_nettype none

module pipelineDatapath (
   input  wire logic                     clk,
   input  wire logic                     rstN,
   input  wire logic                     instrValid,
   input  wire datapathPkg::instrFields_t fields,
   input  wire datapathPkg::ctrl_t        ctrl,
   output logic                          zeroFlag,
   output datapathPkg::aluFlags_t         flags,
   output logic                          wbValid,
   output datapathPkg::regIdx_t           wbReg,
   output datapathPkg::word_t             wbData
);

   import datapathPkg::*;

   regIdx_t readRegB;
   word_t   regDataA;
   word_t   regDataB;
   word_t   exeResult;
   word_t   memResult;
   fwdSel_t fwdA;
   fwdSel_t fwdB;
   idEx_t   idEx;
   exMem_t  exMem;
   memWb_t  memWb;
   logic    exeWrite;
   logic    memWrite;
   logic    regWriteEn;

   // Write enables only count for live instructions
   assign exeWrite   = idEx.valid && idEx.ctrl.regWrite;
   assign memWrite   = exMem.valid && exMem.regWrite;
   assign regWriteEn = memWb.valid && memWb.regWrite;

   registerFile registerFile_i (
      .clk, .rstN,
      .readRegA    (fields.rn),
      .readRegB    (readRegB),
      .writeEnable (regWriteEn),
      .writeReg    (memWb.rd),
      .writeData   (memWb.wbData),
      .readDataA   (regDataA),
      .readDataB   (regDataB)
   );

   forwardingUnit forwardingUnit_i (
      .srcA (fields.rn), .srcB (readRegB),
      .exeDest (idEx.rd), .exeWrite,
      .memDest (exMem.rd), .memWrite,
      .fwdA, .fwdB
   );

   decodeStage decodeStage_i (
      .clk, .rstN, .instrValid, .fields, .ctrl,
      .regDataA, .regDataB, .exeResult, .memResult,
      .fwdA, .fwdB, .readRegB, .zeroFlag, .idEx
   );

   executeStage executeStage_i (.clk, .rstN, .idEx, .exeResult, .flags, .exMem);

   memoryStage memoryStage_i (.clk, .rstN, .exMem, .memResult, .memWb);

   assign wbValid = regWriteEn;
   assign wbReg   = memWb.rd;
   assign wbData  = memWb.wbData;

endmodule

`default_nettype wire

// File: memory/memoryStage.sv
`default_nettype none

module memoryStage (
   input  wire logic               clk,
   input  wire logic               rstN,
   input  wire datapathPkg::exMem_t exMem,
   output datapathPkg::word_t      memResult,
   output datapathPkg::memWb_t     memWb
);

   import datapathPkg::*;

   logic [7:0] dmem [DMEM_BYTES];
   dmemAddr_t  addr;
   logic       doStore;
   word_t      loadWord;
   word_t      loadData;

   // Only the low address bits reach the array
   assign addr    = exMem.aluResult[$bits(dmemAddr_t)-1:0];
   assign doStore = exMem.valid && exMem.memWrite;

   // Little-endian, lowest byte at addr
   always_ff @(posedge clk) begin
      if (doStore) begin
         if (exMem.xferByte) begin
            dmem[addr] <= exMem.storeData[7:0];
         end else begin
            for (int i = 0; i < 8; i++) begin
               dmem[addr + dmemAddr_t'(i)] <= exMem.storeData[8*i +: 8];
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i < 8; i++) begin
         loadWord[8*i +: 8] = dmem[addr + dmemAddr_t'(i)];
      end
   end

   // LDURB clears the upper 56 bits
   assign loadData = exMem.xferByte ? {{(DATA_WIDTH-8){1'b0}}, loadWord[7:0]} : loadWord;

   assign memResult = exMem.memToReg ? loadData : exMem.aluResult;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         memWb <= '0;
      end else begin
         memWb.valid    <= exMem.valid;
         memWb.regWrite <= exMem.regWrite;
         memWb.rd       <= exMem.rd;
         memWb.wbData   <= memResult;
      end
   end

   // One port, so never a read and a write in the same cycle
   noReadAndWrite: assert property (@(posedge clk) disable iff (!rstN)
      exMem.valid |-> !(exMem.memRead && exMem.memWrite))
      else $error("memRead and memWrite both set");

   // Doubleword accesses sit on an 8-byte boundary
   dwordAligned: assert property (@(posedge clk) disable iff (!rstN)
      (exMem.valid && (exMem.memRead || exMem.memWrite) && !exMem.xferByte)
      |-> addr[2:0] == 3'b000)
      else $error("misaligned doubleword access");

endmodule

`default_nettype wire

// File: execute/executeStage.sv
`default_nettype none

module executeStage (
   input  wire logic                clk,
   input  wire logic                rstN,
   input  wire datapathPkg::idEx_t   idEx,
   output datapathPkg::word_t       exeResult,
   output datapathPkg::aluFlags_t   flags,
   output datapathPkg::exMem_t      exMem
);

   import datapathPkg::*;

   logic [5:0] fieldShift;
   word_t      fieldMask;
   word_t      movzVal;
   word_t      movkVal;
   word_t      aluB;
   word_t      aluOut;

   // 16-bit field position picked by shamt
   assign fieldShift = {idEx.shamt, 4'b0000};

   // MOVZ is just imm16 in place with zeros elsewhere
   assign movzVal   = word_t'(idEx.imm16) << fieldShift;
   assign fieldMask = word_t'(16'hFFFF) << fieldShift;

   // MOVK keeps the rest of the old Rd
   assign movkVal = (idEx.db & ~fieldMask) | movzVal;

   always_comb begin
      if (idEx.ctrl.chooseMovz) begin
         aluB = movzVal;
      end else if (idEx.ctrl.chooseMovk) begin
         aluB = movkVal;
      end else begin
         aluB = idEx.opB;
      end
   end

   aluCore aluCore_i (
      .a      (idEx.da),
      .b      (aluB),
      .op     (idEx.ctrl.aluOp),
      .result (aluOut),
      .zero   (),
      .flags  (flags)
   );

   // Back to decode for the execute bypass
   assign exeResult = aluOut;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exMem <= '0;
      end else begin
         exMem.valid     <= idEx.valid;
         exMem.memToReg  <= idEx.ctrl.memToReg;
         exMem.regWrite  <= idEx.ctrl.regWrite;
         exMem.memWrite  <= idEx.ctrl.memWrite;
         exMem.memRead   <= idEx.ctrl.memRead;
         exMem.xferByte  <= idEx.ctrl.xferByte;
         exMem.rd        <= idEx.rd;
         exMem.aluResult <= aluOut;
         // Store data is the forwarded Rd value
         exMem.storeData <= idEx.db;
      end
   end

endmodule

`default_nettype wire

// File: execute/aluCore.sv
`default_nettype none

module aluCore (
   input  wire datapathPkg::word_t  a,
   input  wire datapathPkg::word_t  b,
   input  wire datapathPkg::aluOp_t op,
   output datapathPkg::word_t       result,
   output logic                    zero,
   output datapathPkg::aluFlags_t   flags
);

   import datapathPkg::*;

   // One extra bit to catch the carry out of the top
   logic [DATA_WIDTH:0] sum;
   logic [DATA_WIDTH:0] diff;

   assign sum  = {1'b0, a} + {1'b0, b};
   // a - b as a + ~b + 1, so carry set means no borrow
   assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;

   always_comb begin
      flags.overflow = 1'b0;
      flags.carryOut = 1'b0;
      unique case (op)
         ALU_PASSB: result = b;
         ALU_ADD: begin
            result         = sum[DATA_WIDTH-1:0];
            flags.carryOut = sum[DATA_WIDTH];
            // Same-sign inputs with a different-sign sum
            flags.overflow = (a[DATA_WIDTH-1] == b[DATA_WIDTH-1]) &&
                             (sum[DATA_WIDTH-1] != a[DATA_WIDTH-1]);
         end
         ALU_SUB: begin
            result         = diff[DATA_WIDTH-1:0];
            flags.carryOut = diff[DATA_WIDTH];
            // Opposite-sign inputs and the sign of a flipped
            flags.overflow = (a[DATA_WIDTH-1] != b[DATA_WIDTH-1]) &&
                             (diff[DATA_WIDTH-1] != a[DATA_WIDTH-1]);
         end
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_XOR: result = a ^ b;
         default: result = '0;
      endcase
      flags.negative = result[DATA_WIDTH-1];
   end

   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: design/decodeStage.sv
`default_nettype none

module decodeStage (
   input  wire logic                     clk,
   input  wire logic                     rstN,
   input  wire logic                     instrValid,
   input  wire datapathPkg::instrFields_t fields,
   input  wire datapathPkg::ctrl_t        ctrl,
   input  wire datapathPkg::word_t        regDataA,
   input  wire datapathPkg::word_t        regDataB,
   input  wire datapathPkg::word_t        exeResult,
   input  wire datapathPkg::word_t        memResult,
   input  wire datapathPkg::fwdSel_t      fwdA,
   input  wire datapathPkg::fwdSel_t      fwdB,
   output datapathPkg::regIdx_t           readRegB,
   output logic                          zeroFlag,
   output datapathPkg::idEx_t             idEx
);

   import datapathPkg::*;

   word_t fwdDataA;
   word_t fwdDataB;
   word_t daddrExt;
   word_t immExt;
   word_t candB;

   function automatic word_t pickFwd(input fwdSel_t sel, input word_t regVal,
                                     input word_t exeVal, input word_t memVal);
      word_t picked;
      unique case (sel)
         FWD_EXE: picked = exeVal;
         FWD_MEM: picked = memVal;
         default: picked = regVal;
      endcase
      return picked;
   endfunction

   // Stores and CBZ read Rd on the second port
   assign readRegB = ctrl.reg2Loc ? fields.rd : fields.rm;

   assign fwdDataA = pickFwd(fwdA, regDataA, exeResult, memResult);
   assign fwdDataB = pickFwd(fwdB, regDataB, exeResult, memResult);

   // Address offset is signed, arithmetic immediate is not
   assign daddrExt = {{(DATA_WIDTH-9){fields.daddr9[8]}}, fields.daddr9};
   assign immExt   = {{(DATA_WIDTH-12){1'b0}}, fields.imm12};

   assign candB = ctrl.chooseImm ? immExt : (ctrl.aluSrc ? daddrExt : fwdDataB);

   // Early zero test feeding the branch logic
   assign zeroFlag = (candB == '0);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         idEx <= '0;
      end else begin
         idEx.valid <= instrValid;
         idEx.ctrl  <= ctrl;
         idEx.rd    <= fields.rd;
         idEx.da    <= fwdDataA;
         idEx.db    <= fwdDataB;
         idEx.opB   <= candB;
         idEx.shamt <= fields.shamt;
         idEx.imm16 <= fields.imm16;
      end
   end

endmodule

`default_nettype wire

// File: design/forwardingUnit.sv
`default_nettype none

module forwardingUnit (
   input  wire datapathPkg::regIdx_t srcA,
   input  wire datapathPkg::regIdx_t srcB,
   input  wire datapathPkg::regIdx_t exeDest,
   input  wire logic                exeWrite,
   input  wire datapathPkg::regIdx_t memDest,
   input  wire logic                memWrite,
   output datapathPkg::fwdSel_t     fwdA,
   output datapathPkg::fwdSel_t     fwdB
);

   import datapathPkg::*;

   // Youngest producer wins; register 31 is constant zero
   function automatic fwdSel_t pickSource(input regIdx_t src, input regIdx_t exeRd,
                                          input logic exeWr, input regIdx_t memRd,
                                          input logic memWr);
      fwdSel_t sel;
      sel = FWD_REG;
      if (src != regIdx_t'(ZERO_REG)) begin
         if (exeWr && exeRd == src) sel = FWD_EXE;
         else if (memWr && memRd == src) sel = FWD_MEM;
      end
      return sel;
   endfunction

   always_comb begin
      fwdA = pickSource(srcA, exeDest, exeWrite, memDest, memWrite);
      fwdB = pickSource(srcB, exeDest, exeWrite, memDest, memWrite);
      // An execute-stage bypass needs a live writer behind it
      assert ((fwdA != FWD_EXE && fwdB != FWD_EXE) || exeWrite)
         else $error("execute forward without a register write");
   end

endmodule

`default_nettype wire

// File: design/registerFile.sv
`default_nettype none

module registerFile (
   input  wire logic                clk,
   input  wire logic                rstN,
   input  wire datapathPkg::regIdx_t readRegA,
   input  wire datapathPkg::regIdx_t readRegB,
   input  wire logic                writeEnable,
   input  wire datapathPkg::regIdx_t writeReg,
   input  wire datapathPkg::word_t  writeData,
   output datapathPkg::word_t       readDataA,
   output datapathPkg::word_t       readDataB
);

   import datapathPkg::*;

   word_t regs [REG_COUNT];
   logic  doWrite;

   // Register 31 is never a legal write target
   assign doWrite = writeEnable && (writeReg != regIdx_t'(ZERO_REG));

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (doWrite) begin
         regs[writeReg] <= writeData;
      end
   end

   // Write-through so decode sees a value in the same cycle it is written
   assign readDataA = (doWrite && writeReg == readRegA) ? writeData : regs[readRegA];
   assign readDataB = (doWrite && writeReg == readRegB) ? writeData : regs[readRegB];

   // Zero register holds zero for the whole run
   zeroRegHeld: assert property (@(posedge clk) disable iff (!rstN)
      regs[ZERO_REG] == '0)
      else $error("register 31 was modified");

endmodule

`default_nettype wire

// File: common/datapathPkg.sv
`default_nettype none

package datapathPkg;

   // Datapath geometry
   localparam int DATA_WIDTH = 64;
   localparam int REG_COUNT  = 32;
   localparam int ZERO_REG   = 31;
   localparam int DMEM_BYTES = 256;

   typedef logic [DATA_WIDTH-1:0]         word_t;
   typedef logic [$clog2(REG_COUNT)-1:0]  regIdx_t;
   typedef logic [$clog2(DMEM_BYTES)-1:0] dmemAddr_t;

   // ALU opcodes, same encoding the decoder drives
   typedef enum logic [2:0] {
      ALU_PASSB = 3'b000,
      ALU_ADD   = 3'b010,
      ALU_SUB   = 3'b011,
      ALU_AND   = 3'b100,
      ALU_OR    = 3'b101,
      ALU_XOR   = 3'b110
   } aluOp_t;

   // Operand source in decode; the high bit means "forwarded"
   typedef enum logic [1:0] {
      FWD_REG = 2'b00,
      FWD_MEM = 2'b10,
      FWD_EXE = 2'b11
   } fwdSel_t;

   // Raw instruction fields from the decoder
   typedef struct packed {
      regIdx_t     rd;
      regIdx_t     rm;
      regIdx_t     rn;
      logic [8:0]  daddr9;
      logic [11:0] imm12;
      logic [1:0]  shamt;
      logic [15:0] imm16;
   } instrFields_t;

   typedef struct packed {
      logic   reg2Loc;
      logic   aluSrc;
      logic   chooseImm;
      logic   chooseMovk;
      logic   chooseMovz;
      logic   memToReg;
      logic   regWrite;
      logic   memWrite;
      logic   memRead;
      logic   xferByte;
      aluOp_t aluOp;
   } ctrl_t;

   typedef struct packed {
      logic negative;
      logic overflow;
      logic carryOut;
   } aluFlags_t;

   // Decode to execute
   typedef struct packed {
      logic        valid;
      ctrl_t       ctrl;
      regIdx_t     rd;
      word_t       da;
      word_t       db;
      word_t       opB;
      logic [1:0]  shamt;
      logic [15:0] imm16;
   } idEx_t;

   // Execute to memory
   typedef struct packed {
      logic    valid;
      logic    memToReg;
      logic    regWrite;
      logic    memWrite;
      logic    memRead;
      logic    xferByte;
      regIdx_t rd;
      word_t   aluResult;
      word_t   storeData;
   } exMem_t;

   // Memory to writeback
   typedef struct packed {
      logic    valid;
      logic    regWrite;
      regIdx_t rd;
      word_t   wbData;
   } memWb_t;

endpackage

`default_nettype wire
